// File: bench/lsuPatterns.txt
// columns: pwrite paddr funct3 pwdata expected_prdata expected_pslverr, all hex
// funct3 0 b, 1 h, 2 w, 3 d, 4 bu, 5 hu, 6 wu, 7 illegal; pwrite f ends the list
// doubleword write and read back
1 000 3 0123456789abcdef 0000000000000000 0
0 000 3 0000000000000000 0123456789abcdef 0
// byte stores at every offset of word 1
1 008 3 5a5a5a5a5a5a5a5a 0000000000000000 0
1 008 0 ffffffffffffffb0 0000000000000000 0
1 009 0 ffffffffffffffb1 0000000000000000 0
1 00a 0 ffffffffffffffb2 0000000000000000 0
1 00b 0 ffffffffffffffb3 0000000000000000 0
0 008 3 0000000000000000 5a5a5a5ab3b2b1b0 0
1 00c 0 ffffffffffffffb4 0000000000000000 0
1 00d 0 ffffffffffffffb5 0000000000000000 0
1 00e 0 ffffffffffffffb6 0000000000000000 0
1 00f 0 ffffffffffffffb7 0000000000000000 0
0 008 3 0000000000000000 b7b6b5b4b3b2b1b0 0
// halfword stores at every offset of word 2
1 010 3 5a5a5a5a5a5a5a5a 0000000000000000 0
1 010 1 eeeeeeeeeeeea1a0 0000000000000000 0
1 012 1 eeeeeeeeeeeea3a2 0000000000000000 0
0 010 3 0000000000000000 5a5a5a5aa3a2a1a0 0
1 014 1 eeeeeeeeeeeea5a4 0000000000000000 0
1 016 1 eeeeeeeeeeeea7a6 0000000000000000 0
0 010 3 0000000000000000 a7a6a5a4a3a2a1a0 0
// word stores at both offsets of word 3
1 018 3 5a5a5a5a5a5a5a5a 0000000000000000 0
1 018 2 ddddddddc3c2c1c0 0000000000000000 0
0 018 3 0000000000000000 5a5a5a5ac3c2c1c0 0
1 01c 2 ddddddddc7c6c5c4 0000000000000000 0
0 018 3 0000000000000000 c7c6c5c4c3c2c1c0 0
// signed and unsigned loads from word 4
1 020 3 87654321f00db0a7 0000000000000000 0
0 020 0 0000000000000000 ffffffffffffffa7 0
0 020 4 0000000000000000 00000000000000a7 0
0 022 0 0000000000000000 000000000000000d 0
0 027 0 0000000000000000 ffffffffffffff87 0
0 027 4 0000000000000000 0000000000000087 0
0 020 1 0000000000000000 ffffffffffffb0a7 0
0 020 5 0000000000000000 000000000000b0a7 0
0 022 1 0000000000000000 fffffffffffff00d 0
0 022 5 0000000000000000 000000000000f00d 0
0 020 2 0000000000000000 fffffffff00db0a7 0
0 020 6 0000000000000000 00000000f00db0a7 0
0 024 2 0000000000000000 ffffffff87654321 0
0 024 6 0000000000000000 0000000087654321 0
// misaligned and illegal accesses on word 5
1 028 3 0011223344556677 0000000000000000 0
1 029 1 ffffffffffffffff 0000000000000000 1
1 02a 2 ffffffffffffffff 0000000000000000 1
1 02c 3 ffffffffffffffff 0000000000000000 1
1 028 7 ffffffffffffffff 0000000000000000 1
0 02b 1 0000000000000000 0000000000000000 1
0 02e 2 0000000000000000 0000000000000000 1
0 028 7 0000000000000000 0000000000000000 1
0 028 3 0000000000000000 0011223344556677 0
// end of list
f 000 0 0000000000000000 0000000000000000 0

// File: lsuSubsystem.f
+incdir+rtl
rtl/lsuPkg.sv
rtl/apbPkg.sv
rtl/subwordWrite.sv
rtl/subwordRead.sv
rtl/lsuApbMem.sv
rtl/lsuSubsystem.sv
bench/lsuSubsystemTb.sv

// File: runSim.sh
#!/bin/sh
# build the lsuSubsystem testbench with Verilator and run it
# exits nonzero unless the simulation log reports a clean run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module lsuSubsystemTb \
  -f lsuSubsystem.f -o simLsu > build.log 2>&1 \
  && ./obj_dir/simLsu > sim.log 2>&1 \
  && grep -q "^No errors$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: bench/lsuSubsystemTb.sv
/*
  testbench for the load/store subsystem
  replays APB transfers from a pattern file and checks every response
*/

`timescale 1ns/1ps

module lsuSubsystemTb;
  import lsuPkg::*;
  import apbPkg::*;

  // tokens per pattern line
  localparam int FIELDS = 6;
  // room in the pattern table
  localparam int MAX_PATS = 128;
  localparam int RESET_CYCLES = 16;
  // a pwrite column of f closes the list
  localparam xlenT END_MARK = 64'hf;

  logic   clk;
  logic   arstN;
  apbReqT req;
  apbRspT rsp;

  // pattern table with one hex token per entry
  xlenT patMem [FIELDS*MAX_PATS];
  int   patCount;
  int   cycleCount;
  int   cycleLimit;

  lsuSubsystem lsuSubsystem_inst (
    .clk   (clk),
    .arstN (arstN),
    .req   (req),
    .rsp   (rsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////////////////////////////////////////

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // limit comes from the pattern count once the file is loaded
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: the run needed more than %0d cycles", cycleLimit);
      $display("Errors found");
      $fatal(1, "simulation stopped by the watchdog");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "first mismatch ends the run");
  endtask

  task automatic checkData(input string name, input xlenT got, input xlenT exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkErr(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////////////////////

  task automatic loadPatterns();
    $readmemh("bench/lsuPatterns.txt", patMem);
    patCount = 0;
    while (patCount < MAX_PATS && patMem[FIELDS*patCount] !== END_MARK) begin
      patCount++;
    end
    if (patCount == 0 || patCount == MAX_PATS) begin
      stopOnError("pattern file is empty or lacks its end marker");
    end
  endtask

  // setup then access with the response sampled mid-cycle
  task automatic runTransfer(input int idx);
    int   base;
    logic expErr;
    xlenT expData;
    base    = FIELDS * idx;
    expData = patMem[base+4];
    expErr  = patMem[base+5][0];
    // setup phase
    @(posedge clk);
    #1;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = patMem[base][0];
    req.paddr   = adrT'(patMem[base+1]);
    req.funct3  = funct3T'(patMem[base+2][2:0]);
    req.pwdata  = patMem[base+3];
    @(negedge clk);
    checkErr($sformatf("pready in setup (pattern %0d)", idx), rsp.pready, 1'b0);
    // access phase where the slave must answer at once
    @(posedge clk);
    #1;
    req.penable = 1'b1;
    @(negedge clk);
    if (rsp.pready !== 1'b1) begin
      stopOnError($sformatf("pattern %0d: pready stayed low in the access cycle", idx));
    end
    checkErr($sformatf("pslverr (pattern %0d)", idx), rsp.pslverr, expErr);
    checkData($sformatf("prdata (pattern %0d)", idx), rsp.prdata, expData);
  endtask

  // bus released for one cycle
  task automatic idleCycle();
    @(posedge clk);
    #1;
    req.psel    = 1'b0;
    req.penable = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    arstN      = 1'b0;
    req        = '0;
    cycleCount = 0;
    loadPatterns();
    // two cycles per transfer plus the odd idle cycle
    cycleLimit = RESET_CYCLES + 3 * patCount + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arstN = 1'b1;
    @(negedge clk);
    // quiet bus straight after reset
    checkErr("pready after reset", rsp.pready, 1'b0);
    checkErr("pslverr after reset", rsp.pslverr, 1'b0);
    checkData("prdata after reset", rsp.prdata, '0);
    for (int i = 0; i < patCount; i++) begin
      runTransfer(i);
      // mostly back to back with an idle gap after every fourth
      if (i % 4 == 3) begin
        idleCycle();
      end
    end
    idleCycle();
    @(negedge clk);
    $display("No errors");
    $finish;
  end

endmodule

// File: rtl/lsuSubsystem.sv
/*
  load/store subsystem top
  APB port feeding the store path, the load path and the memory slave
*/

`timescale 1ns/1ps

module lsuSubsystem (
  input  logic           clk,
  input  logic           arstN,
  input  apbPkg::apbReqT req,
  output apbPkg::apbRspT rsp
);
  import lsuPkg::*;

  // store path results
  xlenT     writeData;
  byteMaskT byteMask;
  // raw memory word and its extended load value
  xlenT     readWord;
  xlenT     loadData;

  // store replication and lane mask
  subwordWrite subwordWrite_inst (
    .adrLow    (req.paddr[2:0]),
    .funct3    (req.funct3),
    .storeData (req.pwdata),
    .writeData (writeData),
    .byteMask  (byteMask)
  );

  // load selection and extension
  subwordRead subwordRead_inst (
    .adrLow   (req.paddr[2:0]),
    .funct3   (req.funct3),
    .readWord (readWord),
    .loadData (loadData)
  );

  // bus slave and storage
  lsuApbMem lsuApbMem_inst (
    .clk       (clk),
    .arstN     (arstN),
    .req       (req),
    .writeData (writeData),
    .byteMask  (byteMask),
    .loadData  (loadData),
    .readWord  (readWord),
    .rsp       (rsp)
  );

endmodule

// File: rtl/lsuApbMem.sv
/*
  APB memory slave
  phase tracking, alignment check, byte-writable memory and response mux
*/

`timescale 1ns/1ps

`include "lsuConsts.svh"

module lsuApbMem (
  input  logic             clk,
  input  logic             arstN,
  input  apbPkg::apbReqT   req,
  input  lsuPkg::xlenT     writeData,
  input  lsuPkg::byteMaskT byteMask,
  input  lsuPkg::xlenT     loadData,
  output lsuPkg::xlenT     readWord,
  output apbPkg::apbRspT   rsp
);
  import lsuPkg::*;
  import apbPkg::*;

  apbStateT state;
  apbStateT stateNext;

  // address split
  logic [`MEM_IDX_W-1:0] memIdx;
  byteOffT               adrLow;

  // access checks
  byteOffT alignMask;
  logic    misaligned;
  logic    illegal;
  logic    accessOk;

  // bus phases seen this cycle
  logic setupPhase;
  logic accessPhase;
  logic memWrEn;

  // the data memory, no reset
  xlenT mem [`MEM_WORDS];

  assign memIdx = req.paddr[`ADR_W-1:3];
  assign adrLow = req.paddr[2:0];

  ////////////////////////////////////////////////////////////////////////////
  // alignment and legality
  ////////////////////////////////////////////////////////////////////////////

  // offset bits that must be zero for the access size
  always_comb begin
    case (req.funct3[1:0])
      2'b00: alignMask = 3'b000;
      2'b01: alignMask = 3'b001;
      2'b10: alignMask = 3'b011;
      default: alignMask = 3'b111;
    endcase
  end

  assign misaligned = |(adrLow & alignMask);
  assign illegal    = (req.funct3 == 3'b111);
  assign accessOk   = !misaligned && !illegal;

  ////////////////////////////////////////////////////////////////////////////
  // phase tracking
  ////////////////////////////////////////////////////////////////////////////

  // setup is psel without penable
  assign setupPhase = req.psel && !req.penable;
  // access only counts after a sampled setup
  assign accessPhase = req.psel && req.penable && (state == SETUP);

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (setupPhase) begin
          stateNext = SETUP;
        end
      end
      SETUP: begin
        // slave never stalls, so the access edge always completes
        if (accessPhase) begin
          stateNext = ACCESS;
        end else if (!req.psel) begin
          stateNext = IDLE;
        end
      end
      ACCESS: begin
        // back-to-back transfer goes straight to its setup
        stateNext = setupPhase ? SETUP : IDLE;
      end
      default: begin
        stateNext = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory
  ////////////////////////////////////////////////////////////////////////////

  // legal writes land on the access edge
  assign memWrEn = accessPhase && req.pwrite && accessOk;

  always_ff @(posedge clk) begin
    if (memWrEn) begin
      for (int i = 0; i < `XLEN/8; i++) begin
        if (byteMask[i]) begin
          mem[memIdx][8*i +: 8] <= writeData[8*i +: 8];
        end
      end
    end
  end

  // word fetched at the setup edge, ready for the load path during access
  // any earlier write has already landed by this edge
  always_ff @(posedge clk) begin
    if (setupPhase) begin
      readWord <= mem[memIdx];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rsp         = '0;
    rsp.pready  = accessPhase;
    rsp.pslverr = accessPhase && !accessOk;
    // data only for legal reads, zero otherwise
    if (accessPhase && accessOk && !req.pwrite) begin
      rsp.prdata = loadData;
    end
  end

endmodule

// File: rtl/subwordRead.sv
/*
  load path
  picks the addressed bytes from a memory word and sign or zero extends them
*/

`timescale 1ns/1ps

`include "lsuConsts.svh"

module subwordRead (
  input  lsuPkg::byteOffT adrLow,
  input  lsuPkg::funct3T  funct3,
  input  lsuPkg::xlenT    readWord,
  output lsuPkg::xlenT    loadData
);
  import lsuPkg::*;

  // addressed data moved down to bit 0
  xlenT shifted;

  ////////////////////////////////////////////////////////////////////////////
  // lane selection
  ////////////////////////////////////////////////////////////////////////////

  // little endian, byte n of the word sits at bits 8n+7:8n
  // shift amount is the offset in bytes times eight
  assign shifted = readWord >> {adrLow, 3'b000};

  ////////////////////////////////////////////////////////////////////////////
  // extension
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (funct3)
      // lb, replicate bit 7
      F3_B: begin
        loadData = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      // lh, replicate bit 15
      F3_H: begin
        loadData = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      // lw, replicate bit 31
      F3_W: begin
        loadData = {{(`XLEN-32){shifted[31]}}, shifted[31:0]};
      end
      // lbu
      F3_BU: begin
        loadData = {{(`XLEN-8){1'b0}}, shifted[7:0]};
      end
      // lhu
      F3_HU: begin
        loadData = {{(`XLEN-16){1'b0}}, shifted[15:0]};
      end
      // lwu
      F3_WU: begin
        loadData = {{(`XLEN-32){1'b0}}, shifted[31:0]};
      end
      // ld, offset is always zero when legal
      F3_D: begin
        loadData = readWord;
      end
      // illegal code, result is masked off by the slave
      default: begin
        loadData = '0;
      end
    endcase
  end

endmodule

// File: rtl/subwordWrite.sv
/*
  store path
  replicates store data over all lanes and builds the byte write mask
*/

`timescale 1ns/1ps

`include "lsuConsts.svh"

module subwordWrite (
  input  lsuPkg::byteOffT  adrLow,
  input  lsuPkg::funct3T   funct3,
  input  lsuPkg::xlenT     storeData,
  output lsuPkg::xlenT     writeData,
  output lsuPkg::byteMaskT byteMask
);
  import lsuPkg::*;

  // mask for the access size before it is moved to its offset
  byteMaskT sizeMask;

  ////////////////////////////////////////////////////////////////////////////
  // data replication
  ////////////////////////////////////////////////////////////////////////////

  // copy the low part of the store data into every lane of its size
  // so whichever aligned lane is enabled sees the right bytes
  always_comb begin
    case (funct3[1:0])
      // sb
      2'b00: writeData = {(`XLEN/8){storeData[7:0]}};
      // sh
      2'b01: writeData = {(`XLEN/16){storeData[15:0]}};
      // sw
      2'b10: writeData = {(`XLEN/32){storeData[31:0]}};
      // sd
      default: writeData = storeData;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // byte mask
  ////////////////////////////////////////////////////////////////////////////

  // one bit per byte of the access size
  always_comb begin
    case (funct3[1:0])
      2'b00: sizeMask = byteMaskT'(8'h01);
      2'b01: sizeMask = byteMaskT'(8'h03);
      2'b10: sizeMask = byteMaskT'(8'h0F);
      default: sizeMask = '1;
    endcase
  end

  // slide the size mask up to the addressed byte
  // misaligned offsets spill off the top, the slave blocks those writes anyway
  assign byteMask = sizeMask << adrLow;

endmodule

// File: rtl/apbPkg.sv
/*
  APB bus types
  request and response bundles plus the slave state encoding
*/

package apbPkg;

  // master side of the bus, funct3 rides along as a user field
  typedef struct packed {
    logic          psel;
    logic          penable;
    logic          pwrite;
    lsuPkg::adrT    paddr;
    lsuPkg::xlenT   pwdata;
    lsuPkg::funct3T funct3;
  } apbReqT;

  // slave side of the bus
  typedef struct packed {
    logic         pready;
    logic         pslverr;
    lsuPkg::xlenT prdata;
  } apbRspT;

  // slave phase tracking
  // each state names the bus phase sampled at the last clock edge
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    SETUP  = 2'b01,
    ACCESS = 2'b10
  } apbStateT;

endpackage

// File: rtl/lsuPkg.sv
/*
  load/store datapath types
  data word, byte lanes, addresses and the funct3 size codes
*/

`include "lsuConsts.svh"

package lsuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // plain vectors
  ////////////////////////////////////////////////////////////////////////////

  // one full data word
  typedef logic [`XLEN-1:0] xlenT;

  // one enable bit per byte lane
  typedef logic [`XLEN/8-1:0] byteMaskT;

  // byte position inside a word
  typedef logic [2:0] byteOffT;

  // APB byte address
  typedef logic [`ADR_W-1:0] adrT;

  ////////////////////////////////////////////////////////////////////////////
  // access size codes
  ////////////////////////////////////////////////////////////////////////////

  // funct3 as encoded by RISC-V loads and stores
  // stores share the signed codes, 3'b111 has no meaning
  typedef enum logic [2:0] {
    F3_B  = 3'b000,
    F3_H  = 3'b001,
    F3_W  = 3'b010,
    F3_D  = 3'b011,
    F3_BU = 3'b100,
    F3_HU = 3'b101,
    F3_WU = 3'b110
  } funct3T;

endpackage

// File: rtl/lsuConsts.svh
/*
  load/store datapath constants
  data width, memory depth and the APB byte address width derived from them
*/

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath width
////////////////////////////////////////////////////////////////////////////

// only the 64-bit build is exercised
`define XLEN 64

////////////////////////////////////////////////////////////////////////////
// memory geometry
////////////////////////////////////////////////////////////////////////////

// number of XLEN words held by the slave
`define MEM_WORDS 256
// word index width, log2 of MEM_WORDS
`define MEM_IDX_W 8
// byte address, word index plus 3 offset bits
`define ADR_W (`MEM_IDX_W + 3)

`endif
